// File: verification/div_patterns.txt
# columns in hex: fn (0 unsigned, 1 signed) dividend divisor quotient remainder
# quotient truncates toward zero, remainder takes the dividend's sign
0 00000064 00000007 0000000e 00000002
0 ffffffff 00000001 ffffffff 00000000
0 ffffffff 00010000 0000ffff 0000ffff
0 deadbeef 00001234 000c3ba5 0000076b
0 80000000 ffffffff 00000000 80000000
0 12345678 12345678 00000001 00000000
1 00000064 00000007 0000000e 00000002
1 ffffff9c 00000007 fffffff2 fffffffe
1 00000064 fffffff9 fffffff2 00000002
1 ffffff9c fffffff9 0000000e fffffffe
1 80000000 ffffffff 80000000 00000000
0 12345678 00000000 ffffffff 12345678
1 ffffff9c 00000000 00000001 ffffff9c
1 00000064 00000000 ffffffff 00000064
1 00000003 fffffffb 00000000 00000003
1 fffffffd 00000005 00000000 fffffffd
1 7fffffff 00000002 3fffffff 00000001
1 80000000 00000002 c0000000 00000000

// File: build.f
design/div_msg_pkg.sv
design/div_ctrl_pkg.sv
design/int_div_dpath.sv
design/int_div_ctrl.sv
design/int_div_iterative.sv
verification/int_div_checker.sv
verification/int_div_tb.sv

// File: verification/int_div_tb.sv
/* divider testbench top
   clock and reset, pattern file reader, request driver, LFSR back-pressure */

module int_div_tb;

  logic                   clk = 1'b0;
  logic                   reset;
  div_msg_pkg::div_req_t  req;
  logic                   req_val;
  logic                   req_rdy;
  div_msg_pkg::div_resp_t resp;
  logic                   resp_val;
  logic                   resp_rdy;

  logic [15:0] lfsr_state;
  logic        rdy_bit0;
  logic        rdy_bit1;
  logic [31:0] f_fn;
  logic [31:0] f_a;
  logic [31:0] f_b;
  logic [31:0] f_q;
  logic [31:0] f_r;
  int          fd;
  int          n_fields;
  int          n_sent;
  int          waited;
  logic        aborted;
  string       abort_msg;
  string       line;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  always #2 clk = ~clk;

  int_div_iterative dut_i (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  int_div_checker chk_i (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // --------------------------------------------------
  // back-pressure with ready about one cycle in four
  // --------------------------------------------------

  always @(negedge clk) begin
    if (reset) begin
      resp_rdy = 1'b0;
    end else begin
      lfsr_state = lfsr_step(lfsr_state);
      rdy_bit0   = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
      rdy_bit1   = lfsr_state[0];
      resp_rdy   = rdy_bit0 & rdy_bit1;
    end
  end

  // hold one request until the DUT takes it
  task automatic send_request(input logic fn, input logic [31:0] a, input logic [31:0] b);
    int wait_cnt;
    @(negedge clk);
    req.fn  = div_msg_pkg::div_fn_e'(fn);
    req.a   = a;
    req.b   = b;
    req_val = 1'b1;
    wait_cnt = 0;
    while (!req_rdy && wait_cnt < 100) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (!req_rdy) begin
      aborted   = 1'b1;
      abort_msg = "the DUT did not accept a request within 100 cycles";
    end else begin
      // transfer on the next rising edge
      @(posedge clk);
      n_sent++;
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------

  initial begin
    reset      = 1'b1;
    req        = '0;
    req_val    = 1'b0;
    resp_rdy   = 1'b0;
    lfsr_state = 16'd47609;
    aborted    = 1'b0;
    n_sent     = 0;
    repeat (16) @(negedge clk);
    reset <= 1'b0;

    fd = $fopen("verification/div_patterns.txt", "r");
    if (fd == 0) begin
      aborted   = 1'b1;
      abort_msg = "the pattern file could not be opened";
    end
    // lines starting with # are comments
    while (!aborted && !$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) > 0 && line.len() > 0 && line.getc(0) != "#") begin
        n_fields = $sscanf(line, "%h %h %h %h %h", f_fn, f_a, f_b, f_q, f_r);
        if (n_fields == 5) begin
          chk_i.push_expected(f_q, f_r);
          send_request(f_fn[0], f_a, f_b);
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    @(negedge clk);
    req_val = 1'b0;

    // let the last responses drain
    waited = 0;
    while (!aborted && chk_i.outstanding != 0 && waited < 200) begin
      @(negedge clk);
      waited++;
    end
    if (!aborted && chk_i.outstanding != 0) begin
      aborted   = 1'b1;
      abort_msg = "responses were still missing 200 cycles after the last request";
    end

    if (aborted) begin
      $display("%s", abort_msg);
    end
    $display("tests ok %0d, wrong %0d, protocol errors %0d, requests sent %0d",
             chk_i.pass_cnt, chk_i.fail_cnt, chk_i.proto_err, n_sent);
    if (!aborted && n_sent > 0 && chk_i.fail_cnt == 0 && chk_i.proto_err == 0 &&
        chk_i.pass_cnt == n_sent) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: verification/int_div_checker.sv
/* divider response checker
   expected-value queue, latency, stall stability and ordering checks */

module int_div_checker (
  input logic                   clk,
  input logic                   reset,
  input logic                   req_val,
  input logic                   req_rdy,
  input div_msg_pkg::div_resp_t resp,
  input logic                   resp_val,
  input logic                   resp_rdy
);

  // expected responses, oldest first
  div_msg_pkg::div_resp_t exp_q[$];
  div_msg_pkg::div_resp_t exp_head;
  div_msg_pkg::div_resp_t held_resp;
  int   outstanding = 0;
  int   pass_cnt    = 0;
  int   fail_cnt    = 0;
  int   proto_err   = 0;
  int   lat_cnt     = 0;
  logic in_flight   = 1'b0;
  logic holding     = 1'b0;
  logic released    = 1'b0;

  task automatic push_expected(input div_msg_pkg::div_word_t quot,
                               input div_msg_pkg::div_word_t rem);
    div_msg_pkg::div_resp_t e;
    e.quot = quot;
    e.rem  = rem;
    exp_q.push_back(e);
    outstanding++;
  endtask

  // one line per finished operation
  task automatic check_response();
    if (exp_q.size() == 0) begin
      proto_err++;
      $display("a response was transferred while no request was outstanding");
    end else begin
      exp_head = exp_q.pop_front();
      outstanding--;
      if (resp !== exp_head) begin
        fail_cnt++;
        $display("error @%0t: got quot %h rem %h, expected quot %h rem %h", $time,
                 resp.quot, resp.rem, exp_head.quot, exp_head.rem);
      end else begin
        pass_cnt++;
        $display("test %0d ok: quot %h rem %h", pass_cnt + fail_cnt, resp.quot, resp.rem);
      end
    end
  endtask

  // ports sampled on the rising edge, before the DUT registers move
  always @(posedge clk) begin
    if (reset) begin
      in_flight = 1'b0;
      holding   = 1'b0;
    end else begin
      // first edge out of reset, nothing requested yet
      if (!released) begin
        released = 1'b1;
        if (!req_rdy || resp_val) begin
          proto_err++;
          $display("error @%0t: after reset req_rdy=%b resp_val=%b", $time, req_rdy, resp_val);
        end
      end
      // count edges from the request transfer until resp_val shows up
      if (in_flight) begin
        if (resp_val) begin
          in_flight = 1'b0;
          if (lat_cnt != 32) begin
            proto_err++;
            $display("error @%0t: latency %0d cycles, expected 32", $time, lat_cnt);
          end
        end else begin
          lat_cnt++;
          if (req_rdy) begin
            proto_err++;
            $display("error @%0t: req_rdy high while calculating", $time);
          end
        end
      end
      if (req_val && req_rdy) begin
        in_flight = 1'b1;
        lat_cnt   = 0;
      end
      // a stalled response must hold valid and payload
      if (holding && (!resp_val || resp !== held_resp)) begin
        proto_err++;
        $display("error @%0t: stalled response dropped or changed", $time);
      end
      holding   = resp_val && !resp_rdy;
      held_resp = resp;
      if (resp_val && req_rdy) begin
        proto_err++;
        $display("error @%0t: req_rdy high while a response is pending", $time);
      end
      if (resp_val && resp_rdy) begin
        check_response();
      end
    end
  end

endmodule

// File: design/int_div_iterative.sv
/* iterative 32-bit divider top level
   joins the control FSM and the datapath */

module int_div_iterative (
  input  logic                   clk,
  input  logic                   reset,
  input  div_msg_pkg::div_req_t  req,
  input  logic                   req_val,
  output logic                   req_rdy,
  output div_msg_pkg::div_resp_t resp,
  output logic                   resp_val,
  input  logic                   resp_rdy
);

  // control to datapath commands
  div_ctrl_pkg::div_cmd_t cmd;

  // handshake lives only in the control block
  int_div_ctrl ctrl_i (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .cmd      (cmd)
  );

  // payload path, request in and result out
  int_div_dpath dpath_i (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .cmd   (cmd),
    .resp  (resp)
  );

endmodule

// File: design/int_div_ctrl.sv
/* divider control FSM
   idle/calc/done sequencing, step counter, valid/ready handshake */

module int_div_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_val,
  output logic                   req_rdy,
  output logic                   resp_val,
  input  logic                   resp_rdy,
  output div_ctrl_pkg::div_cmd_t cmd
);

  // one iteration per quotient bit
  localparam int                STEP_W    = 5;
  localparam logic [STEP_W-1:0] LAST_STEP = 5'd31;

  div_ctrl_pkg::div_state_e state;
  logic [STEP_W-1:0]        step_cnt;
  logic                     req_go;
  logic                     resp_go;

  // transfers on both sides
  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // --------------------------------------------------
  // state and step counter
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= div_ctrl_pkg::DIV_IDLE;
      step_cnt <= '0;
    end else begin
      case (state)
        div_ctrl_pkg::DIV_IDLE: begin
          if (req_go) begin
            state    <= div_ctrl_pkg::DIV_CALC;
            step_cnt <= '0;
          end
        end
        div_ctrl_pkg::DIV_CALC: begin
          // counter wraps back to zero on the last step
          step_cnt <= step_cnt + 1'b1;
          if (step_cnt == LAST_STEP) begin
            state <= div_ctrl_pkg::DIV_DONE;
          end
        end
        div_ctrl_pkg::DIV_DONE: begin
          // hold the response until the consumer takes it
          if (resp_go) begin
            state <= div_ctrl_pkg::DIV_IDLE;
          end
        end
        default: state <= div_ctrl_pkg::DIV_IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // output decode
  // --------------------------------------------------

  always_comb begin
    req_rdy  = (state == div_ctrl_pkg::DIV_IDLE);
    resp_val = (state == div_ctrl_pkg::DIV_DONE);
    // load only on the accepting edge
    cmd.load = req_go;
    cmd.step = (state == div_ctrl_pkg::DIV_CALC);
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // one operation in flight, so never accepting while responding
  a_rdy_val_excl : assert property (
    @(posedge clk) disable iff (reset)
    !(req_rdy && resp_val)
  ) else $error("req_rdy and resp_val high together");

  a_cmd_excl : assert property (
    @(posedge clk) disable iff (reset)
    !(cmd.load && cmd.step)
  ) else $error("load and step issued together");

  // response must not drop before it is taken
  a_resp_held : assert property (
    @(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val
  ) else $error("resp_val dropped without a transfer");

endmodule

// File: design/int_div_dpath.sv
/* iterative divider datapath
   operand magnitudes, restoring shift-subtract step, result sign fixup */

module int_div_dpath (
  input  logic                   clk,
  input  logic                   reset,
  input  div_msg_pkg::div_req_t  req,
  input  div_ctrl_pkg::div_cmd_t cmd,
  output div_msg_pkg::div_resp_t resp
);

  localparam int W = div_msg_pkg::DIV_WORD_W;

  // two's complement negate when asked
  function automatic div_msg_pkg::div_word_t cond_neg(
    input div_msg_pkg::div_word_t w,
    input logic                   neg
  );
    return neg ? (~w + 1'b1) : w;
  endfunction

  // --------------------------------------------------
  // request side decode
  // --------------------------------------------------

  logic                   in_signed;
  logic                   a_neg;
  logic                   b_neg;
  div_msg_pkg::div_word_t mag_a;
  div_msg_pkg::div_word_t mag_b;

  assign in_signed = (req.fn == div_msg_pkg::DIV_SIGNED);

  // only signed requests have negative operands
  assign a_neg = in_signed && req.a[W-1];
  assign b_neg = in_signed && req.b[W-1];

  // magnitudes fed into the iteration
  // the most negative value maps to itself, which is still right unsigned
  assign mag_a = cond_neg(req.a, a_neg);
  assign mag_b = cond_neg(req.b, b_neg);

  // --------------------------------------------------
  // shift-subtract step
  // --------------------------------------------------

  // {partial remainder (W+1 bits), quotient / dividend (W bits)}
  logic [2*W:0]           rq_reg;
  div_msg_pkg::div_word_t dvsr_reg;
  logic [2*W:0]           rq_shift;
  logic [W:0]             diff;

  // shift the next dividend bit into the remainder
  assign rq_shift = rq_reg << 1;

  // trial subtraction on the upper part
  // bit W set means the divisor did not fit
  assign diff = rq_shift[2*W:W] - {1'b0, dvsr_reg};

  always_ff @(posedge clk) begin
    if (cmd.load) begin
      // remainder cleared, dividend magnitude in the low word
      rq_reg   <= {{(W+1){1'b0}}, mag_a};
      dvsr_reg <= mag_b;
    end else if (cmd.step) begin
      if (diff[W]) begin
        // restore, quotient bit stays zero
        rq_reg <= rq_shift;
      end else begin
        // keep the difference and set the quotient bit
        rq_reg <= {diff, rq_shift[W-1:1], 1'b1};
      end
    end
  end

  // --------------------------------------------------
  // sign bookkeeping
  // --------------------------------------------------

  logic signed_reg;
  logic quot_neg_reg;
  logic rem_neg_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      signed_reg   <= 1'b0;
      quot_neg_reg <= 1'b0;
      rem_neg_reg  <= 1'b0;
    end else if (cmd.load) begin
      signed_reg   <= in_signed;
      // quotient negative when operand signs differ
      quot_neg_reg <= req.a[W-1] ^ req.b[W-1];
      // remainder follows the dividend
      rem_neg_reg  <= req.a[W-1];
    end
  end

  // --------------------------------------------------
  // response
  // --------------------------------------------------

  // held stable while no command arrives
  always_comb begin
    resp.quot = cond_neg(rq_reg[W-1:0], signed_reg && quot_neg_reg);
    resp.rem  = cond_neg(rq_reg[2*W-1:W], signed_reg && rem_neg_reg);
  end

  // a load in the middle of an iteration would corrupt the partial remainder
  a_no_step_on_load : assert property (
    @(posedge clk) disable iff (reset)
    cmd.load |-> !cmd.step
  ) else $error("dpath got step and load in the same cycle");

endmodule

// File: design/div_ctrl_pkg.sv
/* divider control types
   FSM state encoding and the command bundle sent to the datapath */

package div_ctrl_pkg;

  // --------------------------------------------------
  // FSM states
  // --------------------------------------------------

  // idle waits for a request, calc iterates, done holds the response
  typedef enum logic [1:0] {
    DIV_IDLE = 2'd0,
    DIV_CALC = 2'd1,
    DIV_DONE = 2'd2
  } div_state_e;

  // --------------------------------------------------
  // datapath command
  // --------------------------------------------------

  // at most one field is high in any cycle
  typedef struct packed {
    // capture request and operand magnitudes
    logic load;
    // one shift-subtract iteration
    logic step;
  } div_cmd_t;

endpackage

// File: design/div_msg_pkg.sv
/* request and response message types for the iterative divider
   plus the one-bit signed/unsigned function encoding */

package div_msg_pkg;

  // --------------------------------------------------
  // word size
  // --------------------------------------------------

  // every operand and result word is this wide
  localparam int DIV_WORD_W = 32;

  // one dividend, divisor, quotient or remainder
  typedef logic [DIV_WORD_W-1:0] div_word_t;

  // --------------------------------------------------
  // function select
  // --------------------------------------------------

  // a single bit on the request bus
  typedef enum logic [0:0] {
    DIV_UNSIGNED = 1'b0,
    DIV_SIGNED   = 1'b1
  } div_fn_e;

  // --------------------------------------------------
  // messages
  // --------------------------------------------------

  // 65-bit request
  // fn sits in the top bit, then dividend a, then divisor b
  typedef struct packed {
    div_fn_e   fn;
    div_word_t a;
    div_word_t b;
  } div_req_t;

  // 64-bit response
  // remainder in the upper word and quotient in the lower word,
  // both returned in the same transfer
  typedef struct packed {
    div_word_t rem;
    div_word_t quot;
  } div_resp_t;

endpackage
